// ==== cgra_cfg.svh ====
`ifndef CGRA_CFG_SVH
`define CGRA_CFG_SVH

// array dimensions.
`define CGRA_ROWS 2
`define CGRA_COLS 2

// tracks on each side of a tile.
`define CGRA_TRACKS 4

// block numbers, carried in the high half of the config address.
`define CGRA_BLK_SB 7
`define CGRA_BLK_CB0 6
`define CGRA_BLK_CB1 5
`define CGRA_BLK_LB 4

`endif

// ==== cgra_pkg.sv ====
package cgra_pkg;

	// tile sides, also the side index into a tile track bus.
	typedef enum logic [1:0] {
		SIDE_N = 2'd0,
		SIDE_E = 2'd1,
		SIDE_S = 2'd2,
		SIDE_W = 2'd3
	} side_e;

	// logic block function.
	typedef enum logic [1:0] {
		LB_AND   = 2'd0,
		LB_OR    = 2'd1,
		LB_XOR   = 2'd2,
		LB_PASS0 = 2'd3 // operand 0 straight through.
	} lb_op_e;

	// source of one switch box output.
	// first three walk clockwise from the side after the output's own side.
	typedef enum logic [1:0] {
		SB_CW1 = 2'd0,
		SB_CW2 = 2'd1, // opposite side.
		SB_CW3 = 2'd2,
		SB_LB  = 2'd3
	} sb_sel_e;

endpackage

// ==== cfg_bus_if.sv ====
`timescale 1ns/1ps

// one write per cycle where valid is high, no handshake back.
interface cfg_bus_if;
	logic        valid;
	logic [15:0] tile;
	logic [15:0] blk;
	logic [31:0] data;

	modport host (
		output valid,
		output tile,
		output blk,
		output data
	);

	modport tile_mp (
		input valid,
		input tile,
		input blk,
		input data
	);
endinterface

// ==== connect_box.sv ====
`timescale 1ns/1ps
`include "cgra_cfg.svh"

module connect_box (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic [2*`CGRA_TRACKS-1:0]           tracks,
	input  logic                                cfg_en,
	input  logic [$clog2(2*`CGRA_TRACKS)-1:0]  cfg_sel,
	output logic                                operand
);

	localparam int SEL_W = $clog2(2 * `CGRA_TRACKS);

	logic [SEL_W-1:0] sel_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= '0; // track 0 of the inputs.
		end else if (cfg_en) begin
			sel_q <= cfg_sel;
		end
	end

	// low half are the side inputs, high half the switch box outputs.
	assign operand = tracks[sel_q];

endmodule

// ==== switch_box.sv ====
`timescale 1ns/1ps
`include "cgra_cfg.svh"

module switch_box import cgra_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [4*`CGRA_TRACKS-1:0] track_in,
	input  logic                      lb_out,
	input  logic                      cfg_en,
	input  logic [31:0]               cfg_word,
	output logic [4*`CGRA_TRACKS-1:0] track_out
);

	localparam int T = `CGRA_TRACKS;
	localparam int N_OUT = 4 * T;

	sb_sel_e sel_q [N_OUT];

	// all selects load at once, two bits per output.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < N_OUT; i++) begin
				sel_q[i] <= SB_CW1;
			end
		end else if (cfg_en) begin
			for (int i = 0; i < N_OUT; i++) begin
				sel_q[i] <= sb_sel_e'(cfg_word[2*i +: 2]);
			end
		end
	end

	for (genvar i = 0; i < N_OUT; i++) begin : g_out
		localparam side_e OWN = side_e'(i / T);
		localparam int TRK = i % T;

		logic [1:0] src_side;
		logic       from_side;

		// two bit add wraps north after west.
		assign src_side = OWN + sel_q[i] + 2'd1;
		assign from_side = track_in[src_side * T + TRK]; // same track number.

		assign track_out[i] = (sel_q[i] == SB_LB) ? lb_out : from_side;
	end

endmodule

// ==== logic_block.sv ====
`timescale 1ns/1ps

module logic_block import cgra_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   operand_0,
	input  logic   operand_1,
	input  logic   cfg_en,
	input  lb_op_e cfg_op,
	output logic   result
);

	lb_op_e op_q;
	logic   func;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q <= LB_AND;
		end else if (cfg_en) begin
			op_q <= cfg_op;
		end
	end

	always_comb begin
		case (op_q)
			LB_AND:  func = operand_0 & operand_1;
			LB_OR:   func = operand_0 | operand_1;
			LB_XOR:  func = operand_0 ^ operand_1;
			default: func = operand_0;
		endcase
	end

	// one cycle from operand change to result.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= 1'b0;
		end else begin
			result <= func;
		end
	end

endmodule

// ==== pe_tile.sv ====
`timescale 1ns/1ps
`include "cgra_cfg.svh"

module pe_tile import cgra_pkg::*; #(
	parameter int TILE_ID = 0
) (
	input  logic                      clk,
	input  logic                      rst_n,
	cfg_bus_if.tile_mp                cfg,
	input  logic [4*`CGRA_TRACKS-1:0] track_in,
	output logic [4*`CGRA_TRACKS-1:0] track_out
);

	localparam int T = `CGRA_TRACKS;
	localparam int CB_SEL_W = $clog2(2 * T);

	logic tile_hit;
	logic sb_en;
	logic cb0_en;
	logic cb1_en;
	logic lb_en;
	logic operand_0;
	logic operand_1;
	logic lb_out;

	// address decode.
	assign tile_hit = cfg.valid && (cfg.tile == 16'(TILE_ID));

	// block numbers are distinct, so one enable at most.
	assign sb_en  = tile_hit && (cfg.blk == 16'(`CGRA_BLK_SB));
	assign cb0_en = tile_hit && (cfg.blk == 16'(`CGRA_BLK_CB0));
	assign cb1_en = tile_hit && (cfg.blk == 16'(`CGRA_BLK_CB1));
	assign lb_en  = tile_hit && (cfg.blk == 16'(`CGRA_BLK_LB));

	switch_box u_sb (
		.clk       (clk),
		.rst_n     (rst_n),
		.track_in  (track_in),
		.lb_out    (lb_out),
		.cfg_en    (sb_en),
		.cfg_word  (cfg.data),
		.track_out (track_out)
	);

	// operand 0 taps the north side.
	connect_box u_cb0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.tracks  ({track_out[SIDE_N*T +: T], track_in[SIDE_N*T +: T]}),
		.cfg_en  (cb0_en),
		.cfg_sel (cfg.data[CB_SEL_W-1:0]),
		.operand (operand_0)
	);

	// operand 1 taps the east side.
	connect_box u_cb1 (
		.clk     (clk),
		.rst_n   (rst_n),
		.tracks  ({track_out[SIDE_E*T +: T], track_in[SIDE_E*T +: T]}),
		.cfg_en  (cb1_en),
		.cfg_sel (cfg.data[CB_SEL_W-1:0]),
		.operand (operand_1)
	);

	logic_block u_lb (
		.clk       (clk),
		.rst_n     (rst_n),
		.operand_0 (operand_0),
		.operand_1 (operand_1),
		.cfg_en    (lb_en),
		.cfg_op    (lb_op_e'(cfg.data[1:0])),
		.result    (lb_out)
	);

endmodule

// ==== cgra_array.sv ====
`timescale 1ns/1ps
`include "cgra_cfg.svh"

// row 0 is the north edge, column 0 the west edge.
// edge slot is tile, then outer side in side order, then track.
module cgra_array import cgra_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        cfg_valid,
	input  logic [31:0] cfg_addr,
	input  logic [31:0] cfg_data,
	input  logic [31:0] edge_in,
	output logic [31:0] edge_out
);

	localparam int T = `CGRA_TRACKS;
	localparam int N_TILES = `CGRA_ROWS * `CGRA_COLS;

	function automatic bit is_outer(int row, int col, int side);
		case (side)
			SIDE_N:  return row == 0;
			SIDE_E:  return col == `CGRA_COLS - 1;
			SIDE_S:  return row == `CGRA_ROWS - 1;
			default: return col == 0;
		endcase
	endfunction

	// outer sides ahead of this one on the same tile.
	function automatic int outer_rank(int row, int col, int side);
		int n;
		n = 0;
		for (int k = 0; k < side; k++) begin
			if (is_outer(row, col, k)) begin
				n++;
			end
		end
		return n;
	endfunction

	cfg_bus_if cfg_bus ();

	assign cfg_bus.valid = cfg_valid;
	assign cfg_bus.tile  = cfg_addr[15:0];
	assign cfg_bus.blk   = cfg_addr[31:16];
	assign cfg_bus.data  = cfg_data;

	logic [4*T-1:0] tile_in  [N_TILES];
	logic [4*T-1:0] tile_out [N_TILES];

	for (genvar r = 0; r < `CGRA_ROWS; r++) begin : g_row
		for (genvar c = 0; c < `CGRA_COLS; c++) begin : g_col
			localparam int ID = r * `CGRA_COLS + c;

			pe_tile #(
				.TILE_ID (ID)
			) u_tile (
				.clk       (clk),
				.rst_n     (rst_n),
				.cfg       (cfg_bus.tile_mp),
				.track_in  (tile_in[ID]),
				.track_out (tile_out[ID])
			);

			for (genvar s = 0; s < 4; s++) begin : g_side
				localparam int OPP = (s + 2) % 4; // facing side of the neighbour.
				localparam int SLOT = ID * 2 * T + outer_rank(r, c, s) * T;
				localparam int NB = (s == SIDE_N) ? ID - `CGRA_COLS :
					(s == SIDE_E) ? ID + 1 :
					(s == SIDE_S) ? ID + `CGRA_COLS : ID - 1;

				if (is_outer(r, c, s)) begin : g_edge
					assign tile_in[ID][s*T +: T] = edge_in[SLOT +: T];
					assign edge_out[SLOT +: T] = tile_out[ID][s*T +: T];
				end else begin : g_link
					assign tile_in[ID][s*T +: T] = tile_out[NB][OPP*T +: T];
				end
			end
		end
	end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int HALF_NS = 5,
	parameter int RST_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #HALF_NS clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1; // released away from the rising edge.
	end

endmodule

// ==== cgra_assertions.sv ====
`timescale 1ns/1ps

module cgra_assertions (
	input logic clk,
	input logic rst_n,
	input logic cfg_valid,
	input logic sb_en,
	input logic cb0_en,
	input logic cb1_en,
	input logic lb_en,
	input logic lb_out
);

	// one block per tile takes a write.
	a_one_enable: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({sb_en, cb0_en, cb1_en, lb_en}))
		else $error("more than one block enable high in one tile");

	a_enable_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(sb_en || cb0_en || cb1_en || lb_en) |-> cfg_valid)
		else $error("block enable high while cfg_valid is low");

	// first edge out of reset still sees the cleared register.
	a_lb_cleared: assert property (@(posedge clk) $rose(rst_n) |-> !lb_out)
		else $error("logic block output not zero after reset");

endmodule

// ==== cgra_tb.sv ====
`timescale 1ns/1ps
`include "cgra_cfg.svh"

module cgra_tb import cgra_pkg::*; ();

	localparam int T = `CGRA_TRACKS;
	localparam int N_TILES = `CGRA_ROWS * `CGRA_COLS;
	localparam int N_PASS = N_TILES * 4 * T; // a legal path visits each switch output once.
	localparam int TEST_CYCLES = 12 + 72 + 46 + 54 + 32;
	localparam int TIMEOUT = 6 + TEST_CYCLES + 50;

	logic        clk;
	logic        rst_n;
	logic        cfg_valid;
	logic [31:0] cfg_addr;
	logic [31:0] cfg_data;
	logic [31:0] edge_in;
	logic [31:0] edge_out;

	// shadow config and the modelled logic block registers.
	logic [31:0]    sb_sh  [N_TILES];
	logic [2:0]     cb0_sh [N_TILES];
	logic [2:0]     cb1_sh [N_TILES];
	logic [1:0]     op_sh  [N_TILES];
	logic           lb_q   [N_TILES];
	logic [4*T-1:0] m_tin  [N_TILES];
	logic [4*T-1:0] m_tout [N_TILES];

	int cycle_cnt = 0;
	int check_cnt = 0;
	int err_cnt = 0;
	int err_mark = 0;
	int tests_run = 0;
	int tests_failed = 0;
	bit check_en = 1'b0;

	tb_clk_gen #(.HALF_NS(5), .RST_CYCLES(5)) u_clk (.clk(clk), .rst_n(rst_n));

	cgra_array UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_valid (cfg_valid),
		.cfg_addr  (cfg_addr),
		.cfg_data  (cfg_data),
		.edge_in   (edge_in),
		.edge_out  (edge_out)
	);

	bind pe_tile cgra_assertions u_chk (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_valid (cfg.valid),
		.sb_en     (sb_en),
		.cb0_en    (cb0_en),
		.cb1_en    (cb1_en),
		.lb_en     (lb_en),
		.lb_out    (lb_out)
	);

	function automatic bit is_outer(int t, int s);
		int row;
		int col;
		row = t / `CGRA_COLS;
		col = t % `CGRA_COLS;
		case (s)
			0:       return row == 0;
			1:       return col == `CGRA_COLS - 1;
			2:       return row == `CGRA_ROWS - 1;
			default: return col == 0;
		endcase
	endfunction

	// first edge bit of an outer side.
	function automatic int edge_base(int t, int s);
		int rank;
		rank = 0;
		for (int k = 0; k < s; k++) begin
			if (is_outer(t, k)) rank++;
		end
		return t * 2 * T + rank * T;
	endfunction

	function automatic int neighbour(int t, int s);
		case (s)
			0:       return t - `CGRA_COLS;
			1:       return t + 1;
			2:       return t + `CGRA_COLS;
			default: return t - 1;
		endcase
	endfunction

	// expected edge_out for one edge_in.
	// leaves every tile's tracks in m_tin and m_tout.
	function automatic logic [31:0] route_model(input logic [31:0] ein);
		logic [31:0] eout;
		logic [1:0]  sel;
		int          src;
		eout = '0;
		for (int t = 0; t < N_TILES; t++) m_tout[t] = '0;
		for (int p = 0; p < N_PASS; p++) begin
			for (int t = 0; t < N_TILES; t++) begin
				for (int s = 0; s < 4; s++) begin
					for (int k = 0; k < T; k++) begin
						if (is_outer(t, s))
							m_tin[t][s*T+k] = ein[edge_base(t, s) + k];
						else
							m_tin[t][s*T+k] = m_tout[neighbour(t, s)][((s+2)%4)*T + k];
					end
				end
			end
			for (int t = 0; t < N_TILES; t++) begin
				for (int i = 0; i < 4 * T; i++) begin
					sel = sb_sh[t][2*i +: 2];
					src = (i / T + int'(sel) + 1) % 4; // clockwise from own side.
					m_tout[t][i] = (sel == SB_LB) ? lb_q[t] : m_tin[t][src*T + i%T];
				end
			end
		end
		for (int t = 0; t < N_TILES; t++) begin
			for (int s = 0; s < 4; s++) begin
				if (is_outer(t, s)) begin
					for (int k = 0; k < T; k++) eout[edge_base(t, s) + k] = m_tout[t][s*T+k];
				end
			end
		end
		return eout;
	endfunction

	function automatic logic cb_pick(int t, int side, logic [2:0] sel);
		return (sel < 3'd4) ? m_tin[t][side*T + int'(sel)] : m_tout[t][side*T + int'(sel) - 4];
	endfunction

	function automatic logic lb_func(input logic [1:0] op, input logic a, input logic b);
		case (op)
			LB_AND:  return a & b;
			LB_OR:   return a | b;
			LB_XOR:  return a ^ b;
			default: return a;
		endcase
	endfunction

	function automatic void apply_write(input logic [31:0] addr, input logic [31:0] data);
		int t;
		t = int'(addr[15:0]);
		if (t < N_TILES) begin
			case (addr[31:16])
				`CGRA_BLK_SB:  sb_sh[t] = data;
				`CGRA_BLK_CB0: cb0_sh[t] = data[2:0];
				`CGRA_BLK_CB1: cb1_sh[t] = data[2:0];
				`CGRA_BLK_LB:  op_sh[t] = data[1:0];
				default: ;
			endcase
		end
	endfunction

	always @(posedge clk) cycle_cnt++;

	// reference registers step on the same edge as the DUT.
	always @(posedge clk or negedge rst_n) begin : model
		logic nxt [N_TILES];
		if (!rst_n) begin
			for (int t = 0; t < N_TILES; t++) begin
				sb_sh[t] = '0;
				cb0_sh[t] = '0;
				cb1_sh[t] = '0;
				op_sh[t] = '0;
				lb_q[t] = 1'b0;
			end
		end else begin
			void'(route_model(edge_in));
			for (int t = 0; t < N_TILES; t++)
				nxt[t] = lb_func(op_sh[t], cb_pick(t, SIDE_N, cb0_sh[t]), cb_pick(t, SIDE_E, cb1_sh[t]));
			lb_q = nxt;
			if (cfg_valid) apply_write(cfg_addr, cfg_data);
		end
	end

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR t=%0t %0s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// just before each rising edge.
	initial begin : compare
		forever begin
			@(negedge clk);
			#4;
			if (check_en) check_eq("edge_out", edge_out, route_model(edge_in));
		end
	end

	initial begin : watchdog
		while (cycle_cnt < TIMEOUT) @(negedge clk);
		$display("timeout: no result after %0d cycles", TIMEOUT);
		$display("Simulation failed");
		$finish;
	end

	task automatic write_cfg(input int tile, input int blk, input logic [31:0] data, input bit valid);
		@(negedge clk);
		cfg_valid = valid;
		cfg_addr = {blk[15:0], tile[15:0]};
		cfg_data = data;
		@(negedge clk);
		cfg_valid = 1'b0;
	endtask

	task automatic run_random(input int n);
		repeat (n) begin
			@(negedge clk);
			edge_in = $urandom;
		end
	endtask

	task automatic finish_test(input string name);
		int errs;
		@(posedge clk); // last compare of the test is done.
		errs = err_cnt - err_mark;
		err_mark = err_cnt;
		tests_run++;
		if (errs != 0) tests_failed++;
		$display("test %0s: %0s, %0d mismatches", name, (errs == 0) ? "ok" : "FAILED", errs);
	endtask

	initial begin : stimulus
		logic [31:0] sel_word;
		void'($urandom(90));
		cfg_valid = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		edge_in = '0;
		@(posedge rst_n);
		check_en = 1'b1;

		repeat (4) @(negedge clk);
		#4;
		check_eq("edge_out after reset", edge_out, 32'h0);
		run_random(8); // reset routing with live edges.
		finish_test("reset state");

		// every switch output takes the opposite side.
		for (int t = 0; t < N_TILES; t++) write_cfg(t, `CGRA_BLK_SB, 32'h5555_5555, 1'b1);
		for (int t = 0; t < N_TILES; t++) begin
			write_cfg(t, `CGRA_BLK_CB0, $urandom_range(0, 7), 1'b1);
			write_cfg(t, `CGRA_BLK_CB1, $urandom_range(0, 7), 1'b1);
			write_cfg(t, `CGRA_BLK_LB, $urandom_range(0, 3), 1'b1);
		end
		run_random(40);
		finish_test("straight routing");

		// tile 3 south outputs take its logic block.
		write_cfg(3, `CGRA_BLK_SB, 32'h55FF_5555, 1'b1);
		write_cfg(3, `CGRA_BLK_CB0, 1, 1'b1); // north input track 1.
		write_cfg(3, `CGRA_BLK_CB1, 2, 1'b1);
		for (int op = 0; op < 4; op++) begin
			write_cfg(3, `CGRA_BLK_LB, op, 1'b1);
			run_random(8);
		end
		finish_test("logic through connect boxes");

		for (int n = 0; n < 6; n++) begin
			write_cfg($urandom_range(0, 3), `CGRA_BLK_SB, $urandom, 1'b0);
			run_random(1);
			write_cfg($urandom_range(4, 16'hffff), `CGRA_BLK_SB, $urandom, 1'b1);
			run_random(1);
			write_cfg($urandom_range(0, 3), (n < 4) ? n : $urandom_range(8, 16'hffff), $urandom, 1'b1);
			run_random(1);
		end
		finish_test("address isolation");

		run_random(10);
		sel_word = '0;
		for (int i = 0; i < 4 * T; i++)
			sel_word[2*i +: 2] = ($urandom_range(0, 1) != 0) ? 2'd3 : 2'd1;
		write_cfg(0, `CGRA_BLK_SB, sel_word, 1'b1);
		run_random(20);
		finish_test("reconfiguration");

		@(negedge clk);
		check_en = 1'b0;
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+.
cgra_pkg.sv
cfg_bus_if.sv
connect_box.sv
switch_box.sv
logic_block.sv
pe_tile.sv
cgra_array.sv
tb_clk_gen.sv
cgra_assertions.sv
cgra_tb.sv

// ==== Makefile ====
TOP := cgra_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
